//--- compile.f
armPkg.sv
mainDecoder.sv
aluDecoder.sv
condUnit.sv
controller.sv
tbController.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbController
RTL_TOP   ?= controller
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
RTL_SRCS  ?= armPkg.sv mainDecoder.sv aluDecoder.sv condUnit.sv controller.sv
TB_SRCS   ?= tbController.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tbController.sv
module tbController;
  import armPkg::*;

  localparam int MAX_CYCLES = 400;  // Tests need roughly 90 cycles
  localparam instrT BUBBLE = {COND_AL, 2'b11, 26'd0};  // Unsupported class leaves controls zero

  logic clk;
  logic arstN;
  instrT instrD;
  flagsT flagsE;
  logic stallE, stallM, stallW, flushE, flushW;
  logic [1:0] regSrcD, immSrcD;
  aluCtrlT aluControlE;
  aluOpT aluOperationE;
  logic aluSrcE, invertBE, carryInE, branchTakenE, memToRegE;
  flagsT prevFlagsE;
  logic memWriteM, regWriteM, memToRegM;
  logic regWriteW, memToRegW, pcSrcW, pcWrPendingF;

  flagsT modelFlags;  // Expected NZCV register
  integer seed;
  int cycleCount;

  controller DUT (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic tick;
    @(posedge clk);
    #1;  // Drive point after the edge
  endtask

  task automatic drain;
    instrD = BUBBLE;
    repeat (3) tick;
  endtask

  function automatic instrT dpWord(condT c, logic imm, aluCtrlT op, logic s,
                                   logic [3:0] rn, logic [3:0] rd, logic [11:0] op2);
    return {c, 2'b00, imm, op, s, rn, rd, op2};
  endfunction

  // Pre-indexed immediate offset from base r2
  function automatic instrT memWord(condT c, logic load, logic up, logic [3:0] rd,
                                    logic [11:0] off);
    return {c, 2'b01, 1'b0, 1'b1, up, 1'b0, 1'b0, load, 4'd2, rd, off};
  endfunction

  function automatic instrT branchWord(condT c, logic [23:0] off);
    return {c, 2'b10, 1'b1, 1'b0, off};
  endfunction

  function automatic logic condPasses(condT c, flagsT f);
    case (c)
      COND_EQ: return f[FLAG_Z];
      COND_NE: return !f[FLAG_Z];
      COND_GE: return f[FLAG_N] == f[FLAG_V];
      COND_LT: return f[FLAG_N] != f[FLAG_V];
      COND_AL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Returns {operation class, invert B, carry in}
  function automatic logic [4:0] expectedAlu(aluCtrlT op, logic carry);
    case (op)
      OP_AND, OP_TST:         return {ALU_AND, 2'b00};
      OP_EOR:                 return {ALU_EOR, 2'b00};
      OP_SUB, OP_RSB, OP_CMP: return {ALU_SUB, 2'b11};
      OP_ADC:                 return {ALU_ADD, 1'b0, carry};
      OP_ORR:                 return {ALU_ORR, 2'b00};
      OP_MOV:                 return {ALU_MOV, 2'b00};
      default:                return {ALU_ADD, 2'b00};
    endcase
  endfunction

  task automatic checkDecodeWord(input instrT w, input logic [1:0] regSrc,
                                 input logic [1:0] immSrc, input string name);
    instrD = w;
    #1;
    checkEq(32'(regSrcD), 32'(regSrc), {name, " regSrcD"});
    checkEq(32'(immSrcD), 32'(immSrc), {name, " immSrcD"});
    tick;
  endtask

  task automatic testDecode;
    checkEq(32'({memWriteM, regWriteM, memToRegM}), 32'(0), "M outputs after reset");
    checkEq(32'({regWriteW, memToRegW, pcSrcW}), 32'(0), "W outputs after reset");
    checkEq(32'(prevFlagsE), 32'(0), "prevFlagsE after reset");
    checkEq(32'(pcWrPendingF), 32'(0), "pcWrPendingF after reset");
    checkDecodeWord(dpWord(COND_AL, 1'b1, OP_ADD, 1'b0, 4'd1, 4'd2, 12'h05),
                    2'b00, 2'b00, "DP immediate");
    checkDecodeWord(memWord(COND_AL, 1'b1, 1'b1, 4'd3, 12'h08), 2'b00, 2'b01, "LDR");
    checkDecodeWord(memWord(COND_AL, 1'b0, 1'b1, 4'd3, 12'h08), 2'b10, 2'b01, "STR");
    checkDecodeWord(branchWord(COND_AL, 24'h000004), 2'b01, 2'b10, "B");
  endtask

  task automatic testAluDecode;
    aluCtrlT ops [10];
    logic [31:0] r;
    logic [4:0] expAlu;
    ops = '{OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD, OP_ADC, OP_TST, OP_CMP, OP_ORR, OP_MOV};
    for (int i = 0; i < 10; i++) begin
      r = $random(seed);
      instrD = dpWord(COND_AL, r[4], ops[i], 1'b0, r[8:5], {1'b0, r[2:0]}, r[20:9]);
      tick;
      expAlu = expectedAlu(ops[i], modelFlags[FLAG_C]);
      checkEq(32'(aluControlE), 32'(ops[i]), "aluControlE");
      checkEq(32'(aluOperationE), 32'(expAlu[4:2]), "aluOperationE");
      checkEq(32'(invertBE), 32'(expAlu[1]), "invertBE");
      checkEq(32'(carryInE), 32'(expAlu[0]), "carryInE");
    end
    instrD = BUBBLE;
  endtask

  task automatic testFlags;
    condT conds [4];
    logic [31:0] r;
    logic pass;
    conds = '{COND_EQ, COND_NE, COND_GE, COND_LT};
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      r[17] = 1'b1;  // CMP leaves C set for the second ALU decode pass
      instrD = dpWord(COND_AL, 1'b1, OP_ADD, 1'b1, 4'd1, 4'd3, r[15:4]);  // ADDS
      tick;
      flagsE = r[3:0];  // ALU result for ADDS
      instrD = dpWord(conds[i], 1'b0, OP_ADD, 1'b0, 4'd1, 4'd4, 12'd2);
      tick;
      modelFlags = r[3:0];
      checkEq(32'(prevFlagsE), 32'(modelFlags), "prevFlagsE after ADDS");
      pass = condPasses(conds[i], modelFlags);
      flagsE = r[19:16];
      instrD = dpWord(COND_AL, 1'b0, OP_CMP, 1'b1, 4'd4, 4'd0, 12'd7);
      tick;
      checkEq(32'(regWriteM), 32'(pass), "regWriteM of conditional ADD");
      instrD = BUBBLE;
      tick;
      modelFlags = r[19:16];
      checkEq(32'(regWriteM), 32'(0), "regWriteM of CMP");
      checkEq(32'(prevFlagsE), 32'(modelFlags), "prevFlagsE after CMP");
    end
  endtask

  task automatic testMemBranch;
    instrD = memWord(COND_AL, 1'b0, 1'b0, 4'd5, 12'h10);  // STR with down offset
    tick;
    checkEq(32'(memWriteM), 32'(0), "memWriteM before STR reaches Memory");
    checkEq(32'(aluOperationE), 32'(ALU_SUB), "STR down offset");
    checkEq(32'(aluSrcE), 32'(1), "STR aluSrcE");
    instrD = branchWord(COND_NE, 24'h000010);
    tick;
    checkEq(32'(memWriteM), 32'(1), "memWriteM of STR");
    checkEq(32'(branchTakenE), 32'(condPasses(COND_NE, modelFlags)), "branchTakenE of BNE");
    instrD = memWord(COND_AL, 1'b1, 1'b1, 4'd6, 12'h04);  // LDR
    tick;
    checkEq(32'(memToRegE), 32'(1), "memToRegE of LDR");
    checkEq(32'(aluOperationE), 32'(ALU_ADD), "LDR up offset");
    instrD = BUBBLE;
    tick;
    checkEq(32'(memToRegM), 32'(1), "memToRegM of LDR");
    tick;
    checkEq(32'(memToRegW), 32'(1), "memToRegW of LDR");
    checkEq(32'(regWriteW), 32'(1), "regWriteW of LDR");
  endtask

  task automatic testStallFlush;
    instrD = dpWord(COND_AL, 1'b1, OP_EOR, 1'b0, 4'd1, 4'd7, 12'h01);
    tick;
    stallE = 1'b1;
    instrD = dpWord(COND_AL, 1'b1, OP_ORR, 1'b0, 4'd1, 4'd7, 12'h02);
    tick;
    checkEq(32'(aluControlE), 32'(OP_EOR), "aluControlE held by stallE");
    checkEq(32'(aluOperationE), 32'(ALU_EOR), "aluOperationE held by stallE");
    stallE = 1'b0;
    tick;
    checkEq(32'(aluControlE), 32'(OP_ORR), "aluControlE after stall release");
    instrD = memWord(COND_AL, 1'b0, 1'b1, 4'd5, 12'h00);
    flushE = 1'b1;
    tick;
    instrD = dpWord(COND_AL, 1'b1, OP_ADD, 1'b0, 4'd1, 4'd8, 12'h03);
    tick;
    checkEq(32'(memWriteM), 32'(0), "memWriteM of flushed STR");
    flushE = 1'b0;
    instrD = BUBBLE;
    tick;
    checkEq(32'(regWriteM), 32'(0), "regWriteM of flushed ADD");
    instrD = dpWord(COND_AL, 1'b1, OP_ADD, 1'b0, 4'd1, 4'd9, 12'h03);
    tick;
    instrD = BUBBLE;
    tick;
    checkEq(32'(regWriteM), 32'(1), "regWriteM before flushW");
    flushW = 1'b1;
    tick;
    checkEq(32'(regWriteW), 32'(0), "regWriteW after flushW");
    flushW = 1'b0;
    instrD = memWord(COND_AL, 1'b1, 1'b1, 4'd6, 12'h00);  // LDR
    tick;
    instrD = BUBBLE;
    tick;
    stallM = 1'b1;
    stallW = 1'b1;
    tick;
    checkEq(32'(memToRegM), 32'(1), "memToRegM held by stallM");
    checkEq(32'(regWriteW), 32'(0), "regWriteW held by stallW");
    stallM = 1'b0;
    stallW = 1'b0;
    tick;
    checkEq(32'(regWriteW), 32'(1), "regWriteW after stallW release");
  endtask

  task automatic testPcPending;
    condT conds [3];
    logic pass;
    conds = '{COND_AL, COND_EQ, COND_NE};
    for (int i = 0; i < 3; i++) begin
      pass = condPasses(conds[i], modelFlags);
      if (i == 0) begin
        instrD = dpWord(conds[i], 1'b1, OP_MOV, 1'b0, 4'd0, R15, 12'h40);  // MOV pc
      end else begin
        instrD = branchWord(conds[i], 24'h000020);
      end
      #1;
      checkEq(32'(pcWrPendingF), 32'(1), "pcWrPendingF in Decode");
      tick;
      instrD = BUBBLE;
      #1;
      checkEq(32'(pcWrPendingF), 32'(1), "pcWrPendingF in Execute");
      tick;
      #1;
      checkEq(32'(pcWrPendingF), 32'(pass), "pcWrPendingF in Memory");
      tick;
      #1;
      checkEq(32'(pcWrPendingF), 32'(0), "pcWrPendingF at Writeback");
      checkEq(32'(pcSrcW), 32'(pass), "pcSrcW");
      tick;
    end
  endtask

  initial begin
    clk = 1'b0;
    arstN = 1'b0;
    instrD = BUBBLE;
    flagsE = '0;
    {stallE, stallM, stallW, flushE, flushW} = '0;
    seed = 52537;
    modelFlags = '0;
    cycleCount = 0;
    repeat (4) @(posedge clk);
    #1 arstN = 1'b1;

    testDecode;
    drain;
    testAluDecode;
    testFlags;
    drain;
    testAluDecode;  // Again with nonzero carry in the model
    testMemBranch;
    drain;
    testStallFlush;
    drain;
    testPcPending;

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- controller.sv
module controller (
  input  logic            clk,
  input  logic            arstN,
  input  armPkg::instrT   instrD,
  input  armPkg::flagsT   flagsE,
  input  logic            stallE,
  input  logic            stallM,
  input  logic            stallW,
  input  logic            flushE,
  input  logic            flushW,
  // Decode
  output logic [1:0]      regSrcD,
  output logic [1:0]      immSrcD,
  // Execute
  output armPkg::aluCtrlT aluControlE,
  output armPkg::aluOpT   aluOperationE,
  output logic            aluSrcE,
  output logic            invertBE,
  output logic            carryInE,
  output logic            branchTakenE,
  output logic            memToRegE,
  output armPkg::flagsT   prevFlagsE,
  // Memory
  output logic            memWriteM,
  output logic            regWriteM,
  output logic            memToRegM,
  // Writeback
  output logic            regWriteW,
  output logic            memToRegW,
  output logic            pcSrcW,
  // To hazard unit
  output logic            pcWrPendingF
);
  import armPkg::*;

  decodeCtrlT ctrlD;
  decodeCtrlT ctrlE;
  condT       condE;
  logic       doNotWriteE;
  memCtrlT    memCtrlE;
  memCtrlT    memCtrlM;
  memCtrlT    memCtrlW;

  mainDecoder uMainDecoder (
    .instrD (instrD),
    .ctrlD  (ctrlD)
  );

  assign regSrcD = ctrlD.regSrc;
  assign immSrcD = ctrlD.immSrc;

  // Execute register, stall wins over flush
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlE <= '0;
      condE <= '0;
    end else if (!stallE) begin
      if (flushE) begin
        ctrlE <= '0;          // Bubble writes nothing
        condE <= '0;
      end else begin
        ctrlE <= ctrlD;
        condE <= instrD[31:28];
      end
    end
  end

  aluDecoder uAluDecoder (
    .aluOpE        (ctrlE.aluOp),
    .aluControlE   (ctrlE.aluControl),
    .carryFlagE    (prevFlagsE[FLAG_C]),
    .aluOperationE (aluOperationE),
    .invertBE      (invertBE),
    .carryInE      (carryInE),
    .doNotWriteE   (doNotWriteE)
  );

  condUnit uCondUnit (
    .clk          (clk),
    .arstN        (arstN),
    .stallE       (stallE),
    .condE        (condE),
    .flagsE       (flagsE),
    .flagWriteE   (ctrlE.flagWrite),
    .ctrlE        (ctrlE),
    .doNotWriteE  (doNotWriteE),
    .memCtrlE     (memCtrlE),
    .branchTakenE (branchTakenE),
    .prevFlagsE   (prevFlagsE)
  );

  assign aluControlE = ctrlE.aluControl;
  assign aluSrcE     = ctrlE.aluSrc;
  assign memToRegE   = ctrlE.memToReg;

  // Memory register, no flush
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memCtrlM <= '0;
    end else if (!stallM) begin
      memCtrlM <= memCtrlE;
    end
  end

  assign memWriteM = memCtrlM.memWrite;
  assign regWriteM = memCtrlM.regWrite;
  assign memToRegM = memCtrlM.memToReg;

  // Writeback register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memCtrlW <= '0;
    end else if (!stallW) begin
      if (flushW) begin
        memCtrlW <= '0;
      end else begin
        memCtrlW <= memCtrlM;
      end
    end
  end

  assign regWriteW = memCtrlW.regWrite;
  assign memToRegW = memCtrlW.memToReg;
  assign pcSrcW    = memCtrlW.pcSrc;

  // PC write still in flight in D, E or M
  assign pcWrPendingF = ctrlD.pcSrc | ctrlE.pcSrc | memCtrlM.pcSrc;

endmodule

//--- condUnit.sv
module condUnit (
  input  logic               clk,
  input  logic               arstN,
  input  logic               stallE,
  input  armPkg::condT       condE,
  input  armPkg::flagsT      flagsE,
  input  logic [1:0]         flagWriteE,
  input  armPkg::decodeCtrlT ctrlE,
  input  logic               doNotWriteE,
  output armPkg::memCtrlT    memCtrlE,
  output logic               branchTakenE,
  output armPkg::flagsT      prevFlagsE
);
  import armPkg::*;

  flagsT flagsQ;
  logic  condExE;

  // Condition test against the stored NZCV
  always_comb begin
    case (condE)
      COND_EQ: condExE = flagsQ[FLAG_Z];
      COND_NE: condExE = ~flagsQ[FLAG_Z];
      COND_GE: condExE = (flagsQ[FLAG_N] == flagsQ[FLAG_V]);
      COND_LT: condExE = (flagsQ[FLAG_N] != flagsQ[FLAG_V]);
      COND_AL: condExE = 1'b1;
      default: condExE = 1'b0;  // Unsupported codes never execute
    endcase
  end

  // NZ and CV halves update independently
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flagsQ <= '0;
    end else if (condExE && !stallE) begin
      if (flagWriteE[1]) begin
        flagsQ[FLAG_N:FLAG_Z] <= flagsE[FLAG_N:FLAG_Z];
      end
      if (flagWriteE[0]) begin
        flagsQ[FLAG_C:FLAG_V] <= flagsE[FLAG_C:FLAG_V];
      end
    end
  end

  assign prevFlagsE = flagsQ;

  // Side effects only when the condition passes
  assign memCtrlE.memWrite = ctrlE.memWrite & condExE;
  assign memCtrlE.memToReg = ctrlE.memToReg;
  assign memCtrlE.regWrite = ctrlE.regWrite & condExE & ~doNotWriteE;  // TST/CMP
  assign memCtrlE.pcSrc    = ctrlE.pcSrc & condExE;
  assign branchTakenE      = ctrlE.branch & condExE;

endmodule

//--- aluDecoder.sv
module aluDecoder (
  input  logic            aluOpE,
  input  armPkg::aluCtrlT aluControlE,
  input  logic            carryFlagE,
  output armPkg::aluOpT   aluOperationE,
  output logic            invertBE,
  output logic            carryInE,
  output logic            doNotWriteE
);
  import armPkg::*;

  always_comb begin
    // Plain add unless the opcode says otherwise
    aluOperationE = ALU_ADD;
    invertBE      = 1'b0;
    carryInE      = 1'b0;
    doNotWriteE   = 1'b0;

    if (aluOpE) begin
      case (aluControlE)
        OP_AND: aluOperationE = ALU_AND;
        OP_EOR: aluOperationE = ALU_EOR;
        OP_SUB, OP_RSB: begin
          aluOperationE = ALU_SUB;
          invertBE      = 1'b1;   // A + ~B + 1
          carryInE      = 1'b1;
        end
        OP_ADD: aluOperationE = ALU_ADD;
        OP_ADC: begin
          aluOperationE = ALU_ADD;
          carryInE      = carryFlagE;  // Stored C
        end
        OP_TST: begin
          aluOperationE = ALU_AND;
          doNotWriteE   = 1'b1;   // Flags only
        end
        OP_CMP: begin
          aluOperationE = ALU_SUB;
          invertBE      = 1'b1;
          carryInE      = 1'b1;
          doNotWriteE   = 1'b1;
        end
        OP_ORR: aluOperationE = ALU_ORR;
        OP_MOV: aluOperationE = ALU_MOV;
        default: aluOperationE = ALU_ADD;
      endcase
    end
  end

endmodule

//--- mainDecoder.sv
module mainDecoder (
  input  armPkg::instrT      instrD,
  output armPkg::decodeCtrlT ctrlD
);
  import armPkg::*;

  logic [1:0] opField;
  logic       immBit;
  logic       loadBit;
  logic [3:0] rdField;

  assign opField = instrD[27:26];
  assign immBit  = instrD[25];
  assign loadBit = instrD[20];   // L bit for memory, S bit for data processing
  assign rdField = instrD[15:12];

  always_comb begin
    ctrlD            = '0;
    ctrlD.aluControl = OP_ADD;   // Address and branch target add

    case (opField)
      2'b00: begin               // Data processing
        ctrlD.aluSrc     = immBit;
        ctrlD.regWrite   = 1'b1;
        ctrlD.aluOp      = 1'b1;
        ctrlD.flagWrite  = {2{loadBit}};
        ctrlD.aluControl = instrD[24:21];
      end

      2'b01: begin               // LDR / STR
        ctrlD.immSrc = 2'b01;
        ctrlD.aluSrc = ~immBit;  // I set means register offset
        // Offset direction still goes through the ALU decoder
        ctrlD.aluOp      = 1'b1;
        ctrlD.aluControl = instrD[23] ? OP_ADD : OP_SUB;
        if (loadBit) begin
          ctrlD.memToReg = 1'b1;
          ctrlD.regWrite = 1'b1;
        end else begin
          ctrlD.regSrc   = 2'b10;  // Read Rd as store data
          ctrlD.memWrite = 1'b1;
        end
      end

      2'b10: begin               // B
        ctrlD.regSrc = 2'b01;    // PC as first operand
        ctrlD.immSrc = 2'b10;
        ctrlD.aluSrc = 1'b1;
        ctrlD.branch = 1'b1;
      end

      default: begin
        // Unsupported class, leave as a bubble
        ctrlD.aluControl = OP_ADD;
      end
    endcase

    // Any write to the PC redirects fetch
    ctrlD.pcSrc = ctrlD.branch | (ctrlD.regWrite & (rdField == R15));
  end

endmodule

//--- armPkg.sv
package armPkg;

  // Field and flag widths
  typedef logic [31:0] instrT;
  typedef logic [3:0]  condT;
  typedef logic [3:0]  flagsT;    // NZCV, N in bit 3
  typedef logic [3:0]  aluCtrlT;  // Data-processing opcode
  typedef logic [2:0]  aluOpT;    // ALU operation class

  // Control word produced in Decode
  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;
    logic       memToReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       aluOp;       // Opcode goes through the ALU decoder
    logic [1:0] flagWrite;   // [1] NZ, [0] CV
    logic       pcSrc;
    aluCtrlT    aluControl;
  } decodeCtrlT;

  // Gated controls carried from Memory to Writeback
  typedef struct packed {
    logic memWrite;
    logic memToReg;
    logic regWrite;
    logic pcSrc;
  } memCtrlT;

  // Data-processing opcodes, instr[24:21]
  localparam aluCtrlT OP_AND = 4'b0000;
  localparam aluCtrlT OP_EOR = 4'b0001;
  localparam aluCtrlT OP_SUB = 4'b0010;
  localparam aluCtrlT OP_RSB = 4'b0011;
  localparam aluCtrlT OP_ADD = 4'b0100;
  localparam aluCtrlT OP_ADC = 4'b0101;
  localparam aluCtrlT OP_TST = 4'b1000;
  localparam aluCtrlT OP_CMP = 4'b1010;
  localparam aluCtrlT OP_ORR = 4'b1100;
  localparam aluCtrlT OP_MOV = 4'b1101;

  // ALU operation classes
  localparam aluOpT ALU_ADD = 3'd0;
  localparam aluOpT ALU_SUB = 3'd1;
  localparam aluOpT ALU_AND = 3'd2;
  localparam aluOpT ALU_ORR = 3'd3;
  localparam aluOpT ALU_EOR = 3'd4;
  localparam aluOpT ALU_MOV = 3'd5;

  // Condition codes, instr[31:28]
  localparam condT COND_EQ = 4'b0000;
  localparam condT COND_NE = 4'b0001;
  localparam condT COND_GE = 4'b1010;
  localparam condT COND_LT = 4'b1011;
  localparam condT COND_AL = 4'b1110;

  // Bit positions inside flagsT
  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  localparam logic [3:0] R15 = 4'd15;  // PC

endpackage
